/* source/xm_bus_pkg.sv */
package xm_bus_pkg;

	// Data and address width of the external bus
	localparam int word_bits = 16;
	localparam int byte_lanes = word_bits / 8;

	typedef enum logic {
		op_read,
		op_write
	} xm_op_e;

	typedef enum logic {
		size_byte,
		size_word
	} xm_size_e;

	// Interfacer FSM states
	typedef enum logic [1:0] {
		st_idle,
		st_read,
		st_write
	} bus_state_e;

	// Interfacer to memory
	typedef struct packed {
		logic rd_en;
		logic wr_en;
		logic [word_bits-1:0] addr;
		logic [word_bits-1:0] wr_data;
		logic [byte_lanes-1:0] byte_en;
	} bus_req_t;

	// Memory back to interfacer
	typedef struct packed {
		logic done; // One-cycle pulse
		logic [word_bits-1:0] rd_data; // Valid with done
	} bus_rsp_t;

endpackage : xm_bus_pkg

/* source/byte_lane_unit.sv */
`timescale 1ns/1ps

module byte_lane_unit (
	input xm_bus_pkg::xm_size_e size,
	input logic [xm_bus_pkg::word_bits-1:0] addr,
	input logic [xm_bus_pkg::word_bits-1:0] wr_data,
	input xm_bus_pkg::xm_size_e req_size,
	input logic [xm_bus_pkg::word_bits-1:0] req_addr,
	input logic [xm_bus_pkg::word_bits-1:0] bus_rd_data,
	output logic bad_addr,
	output logic [xm_bus_pkg::word_bits-1:0] lane_wr_data,
	output logic [xm_bus_pkg::byte_lanes-1:0] byte_en,
	output logic [xm_bus_pkg::word_bits-1:0] rd_extract
);
	import xm_bus_pkg::*;

	// Words must sit on an even address
	assign bad_addr = (size == size_word) && addr[0];

	// Write side works on the incoming request
	always_comb begin
		if (size == size_word) begin
			lane_wr_data = wr_data;
			byte_en = 2'b11;
		end else if (addr[0]) begin
			lane_wr_data = {wr_data[7:0], 8'h00}; // Odd address is the high lane
			byte_en = 2'b10;
		end else begin
			lane_wr_data = {8'h00, wr_data[7:0]};
			byte_en = 2'b01;
		end
	end

	// Read side works on the registered request, since the core
	// only holds its inputs in the accept cycle
	always_comb begin
		if (req_size == size_word) begin
			rd_extract = bus_rd_data;
		end else if (req_addr[0]) begin
			rd_extract = {8'h00, bus_rd_data[15:8]}; // Zero-extended
		end else begin
			rd_extract = {8'h00, bus_rd_data[7:0]};
		end
	end

endmodule : byte_lane_unit

/* source/access_timer.sv */
`timescale 1ns/1ps

module access_timer #(
	parameter int TIMEOUT_CYCLES = 8
) (
	input logic clk,
	input logic reset,
	input logic busy,
	input logic done,
	output logic timeout
);

	localparam int cnt_bits = $clog2(TIMEOUT_CYCLES + 1);

	logic [cnt_bits-1:0] count;

	always_ff @(posedge clk) begin
		if (reset) begin
			count <= '0;
			timeout <= 1'b0;
		end else if (!busy || done) begin
			count <= '0; // Idle or answered
			timeout <= 1'b0;
		end else if (count == cnt_bits'(TIMEOUT_CYCLES - 1)) begin
			count <= '0;
			timeout <= 1'b1; // Single-cycle pulse
		end else begin
			count <= count + 1'b1;
			timeout <= 1'b0;
		end
	end

	// A device answering in the same cycle would be reported as an error
	a_no_timeout_with_done : assert property (
		@(posedge clk) disable iff (reset) !(timeout && done)
	);

endmodule : access_timer

/* source/ext_memory.sv */
`timescale 1ns/1ps

module ext_memory #(
	parameter int WAIT_STATES = 2,
	parameter int MEM_WORDS = 256
) (
	input logic clk,
	input logic reset,
	input xm_bus_pkg::bus_req_t bus_req,
	output xm_bus_pkg::bus_rsp_t bus_rsp
);
	import xm_bus_pkg::*;

	localparam int idx_bits = $clog2(MEM_WORDS);
	localparam int cnt_bits = $clog2(WAIT_STATES + 2);

	logic [word_bits-1:0] mem [MEM_WORDS];
	logic [cnt_bits-1:0] wait_cnt;
	logic [idx_bits-1:0] word_idx;
	logic [word_bits-1:0] rd_q;
	logic done_q;
	logic hold; // Answered, waiting for the enable to drop
	logic hit;
	logic fire;

	// Decode on the word address
	assign word_idx = bus_req.addr[idx_bits:1];
	assign hit = (bus_req.rd_en || bus_req.wr_en)
		&& ({1'b0, bus_req.addr[word_bits-1:1]} < word_bits'(MEM_WORDS));
	assign fire = hit && !hold && (wait_cnt == cnt_bits'(WAIT_STATES));

	always_ff @(posedge clk) begin
		if (reset) begin
			wait_cnt <= '0;
			done_q <= 1'b0;
			hold <= 1'b0;
		end else begin
			done_q <= fire;
			if (!hit) begin
				wait_cnt <= '0; // Enable dropped or out of range
				hold <= 1'b0;
			end else if (fire) begin
				wait_cnt <= '0;
				hold <= 1'b1;
			end else if (!hold) begin
				wait_cnt <= wait_cnt + 1'b1;
			end
		end
	end

	// Storage and read data
	always_ff @(posedge clk) begin
		if (fire) begin
			if (bus_req.wr_en) begin
				for (int b = 0; b < byte_lanes; b++) begin
					if (bus_req.byte_en[b])
						mem[word_idx][b*8 +: 8] <= bus_req.wr_data[b*8 +: 8];
				end
			end
			rd_q <= mem[word_idx];
		end
	end

	assign bus_rsp = '{done: done_q, rd_data: rd_q};

endmodule : ext_memory

/* source/bus_interfacer.sv */
`timescale 1ns/1ps

module bus_interfacer (
	input logic clk,
	input logic reset,
	input logic en,
	input xm_bus_pkg::xm_op_e op,
	input xm_bus_pkg::xm_size_e size,
	input logic [xm_bus_pkg::word_bits-1:0] addr,
	input logic [xm_bus_pkg::word_bits-1:0] wr_data,
	input logic timeout,
	input xm_bus_pkg::bus_rsp_t bus_rsp,
	output logic ready,
	output logic bad_addr,
	output logic rd_err,
	output logic wr_err,
	output logic [xm_bus_pkg::word_bits-1:0] rd_data,
	output logic busy,
	output xm_bus_pkg::bus_req_t bus_req
);
	import xm_bus_pkg::*;

	bus_state_e state;
	bus_state_e next_state;

	logic [word_bits-1:0] addr_r;
	logic [word_bits-1:0] data_r; // Write data, then read result
	xm_size_e size_r;
	logic [byte_lanes-1:0] be_r;

	logic [word_bits-1:0] lane_wr_data;
	logic [word_bits-1:0] rd_extract;
	logic [byte_lanes-1:0] byte_en;
	logic accept;
	logic finish;

	byte_lane_unit lane_i (
		.size(size),
		.addr(addr),
		.wr_data(wr_data),
		.req_size(size_r),
		.req_addr(addr_r),
		.bus_rd_data(bus_rsp.rd_data),
		.bad_addr(bad_addr),
		.lane_wr_data(lane_wr_data),
		.byte_en(byte_en),
		.rd_extract(rd_extract)
	);

	assign ready = (state == st_idle);
	assign busy = !ready; // Timer runs for the whole access
	assign accept = ready && en && !bad_addr;
	assign finish = bus_rsp.done || timeout;

	always_comb begin
		next_state = state;
		case (state)
			st_idle: begin
				if (accept)
					next_state = (op == op_read) ? st_read : st_write;
			end
			st_read, st_write: begin
				if (finish)
					next_state = st_idle;
			end
			default: next_state = st_idle;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= st_idle;
			rd_err <= 1'b0;
			wr_err <= 1'b0;
			data_r <= '0;
		end else begin
			state <= next_state;

			// Flags live until the next accepted request
			if (accept) begin
				rd_err <= 1'b0;
				wr_err <= 1'b0;
			end else if (timeout) begin
				rd_err <= (state == st_read);
				wr_err <= (state == st_write);
			end

			if (accept && op == op_write)
				data_r <= lane_wr_data;
			else if (state == st_read && bus_rsp.done)
				data_r <= rd_extract; // Lane already selected and extended
		end
	end

	// Request fields captured once at accept
	always_ff @(posedge clk) begin
		if (accept) begin
			addr_r <= addr;
			size_r <= size;
			be_r <= byte_en;
		end
	end

	assign bus_req = '{
		rd_en: (state == st_read),
		wr_en: (state == st_write),
		addr: addr_r,
		wr_data: data_r,
		byte_en: be_r
	};
	assign rd_data = data_r;

	a_one_enable : assert property (
		@(posedge clk) disable iff (reset) !(bus_req.rd_en && bus_req.wr_en)
	);

	// A misaligned word never reaches the bus
	a_bad_addr_ignored : assert property (
		@(posedge clk) disable iff (reset)
		((bus_req.rd_en || bus_req.wr_en) && size_r == size_word) |-> !bus_req.addr[0]
	);

endmodule : bus_interfacer

/* source/xm_bus_top.sv */
`timescale 1ns/1ps

module xm_bus_top #(
	parameter int WAIT_STATES = 2,
	parameter int TIMEOUT_CYCLES = 8,
	parameter int MEM_WORDS = 256
) (
	input logic clk,
	input logic reset,
	input logic en,
	input xm_bus_pkg::xm_op_e op,
	input xm_bus_pkg::xm_size_e size,
	input logic [xm_bus_pkg::word_bits-1:0] addr,
	input logic [xm_bus_pkg::word_bits-1:0] wr_data,
	output logic ready,
	output logic bad_addr,
	output logic rd_err,
	output logic wr_err,
	output logic [xm_bus_pkg::word_bits-1:0] rd_data
);
	import xm_bus_pkg::*;

	bus_req_t bus_req;
	bus_rsp_t bus_rsp;
	logic busy;
	logic timeout;

	bus_interfacer interfacer_i (
		.clk(clk),
		.reset(reset),
		.en(en),
		.op(op),
		.size(size),
		.addr(addr),
		.wr_data(wr_data),
		.timeout(timeout),
		.bus_rsp(bus_rsp),
		.ready(ready),
		.bad_addr(bad_addr),
		.rd_err(rd_err),
		.wr_err(wr_err),
		.rd_data(rd_data),
		.busy(busy),
		.bus_req(bus_req)
	);

	access_timer #(
		.TIMEOUT_CYCLES(TIMEOUT_CYCLES)
	) timer_i (
		.clk(clk),
		.reset(reset),
		.busy(busy),
		.done(bus_rsp.done),
		.timeout(timeout)
	);

	ext_memory #(
		.WAIT_STATES(WAIT_STATES),
		.MEM_WORDS(MEM_WORDS)
	) memory_i (
		.clk(clk),
		.reset(reset),
		.bus_req(bus_req),
		.bus_rsp(bus_rsp)
	);

	// The memory must answer before the timer gives up
	a_timeout_covers_wait : assert property (
		@(posedge clk) TIMEOUT_CYCLES > WAIT_STATES + 1
	);

endmodule : xm_bus_top

/* testbench/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen #(
	parameter int RESET_CYCLES = 16
) (
	output logic clk,
	output logic reset
);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk; // 10 ns period
	end

	initial begin
		reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		#1;
		reset = 1'b0; // Released off the edge like the other inputs
	end

endmodule : tb_clock_gen

/* testbench/xm_bus_tb.sv */
`timescale 1ns/1ps

module xm_bus_tb;
	import xm_bus_pkg::*;

	localparam int wait_states = 2;
	localparam int timeout_cycles = 8;
	localparam int mem_words = 256;
	localparam int reset_cycles = 16;
	localparam int n_accesses = 69; // 13 directed, 16 fill and 40 random
	localparam int watchdog_cycles = reset_cycles + n_accesses * (timeout_cycles + 4);

	logic clk;
	logic reset;
	logic en;
	xm_op_e op;
	xm_size_e size;
	logic [word_bits-1:0] addr;
	logic [word_bits-1:0] wr_data;
	logic ready;
	logic bad_addr;
	logic rd_err;
	logic wr_err;
	logic [word_bits-1:0] rd_data;

	logic [7:0] ref_mem [2*mem_words]; // Byte-wide reference, little-endian
	logic [word_bits-1:0] exp_data;
	logic exp_rd_err;
	logic exp_wr_err;
	logic check_data; // Only mapped reads carry data to compare
	logic misalign_armed;
	string test_name;
	int error_count;
	int errors_at_start;
	int pass_count;
	int fail_count;
	int seed;

	tb_clock_gen #(.RESET_CYCLES(reset_cycles)) clock_gen_i (.clk(clk), .reset(reset));

	xm_bus_top #(
		.WAIT_STATES(wait_states),
		.TIMEOUT_CYCLES(timeout_cycles),
		.MEM_WORDS(mem_words)
	) xm_bus_top_i (
		.clk(clk),
		.reset(reset),
		.en(en),
		.op(op),
		.size(size),
		.addr(addr),
		.wr_data(wr_data),
		.ready(ready),
		.bad_addr(bad_addr),
		.rd_err(rd_err),
		.wr_err(wr_err),
		.rd_data(rd_data)
	);

	task automatic note_mismatch(input string what, input logic [15:0] expected,
			input logic [15:0] actual);
		$display("FAIL %s %s expected %h actual %h", test_name, what, expected, actual);
		error_count++;
	endtask

	task automatic note_failure(input string what);
		$display("%s: %s", test_name, what);
		error_count++;
	endtask

	// Sampled at the first edge where ready is back
	a_read_data : assert property (
		@(posedge clk) disable iff (reset)
		($rose(ready) && check_data) |-> (rd_data == exp_data)
	) else note_mismatch("rd_data", exp_data, rd_data);

	a_read_error : assert property (
		@(posedge clk) disable iff (reset)
		$rose(ready) |-> (rd_err == exp_rd_err)
	) else note_mismatch("rd_err", {15'd0, exp_rd_err}, {15'd0, rd_err});

	a_write_error : assert property (
		@(posedge clk) disable iff (reset)
		$rose(ready) |-> (wr_err == exp_wr_err)
	) else note_mismatch("wr_err", {15'd0, exp_wr_err}, {15'd0, wr_err});

	// Every aligned request must start an access
	a_request_accepted : assert property (
		@(posedge clk) disable iff (reset)
		(en && !misalign_armed) |=> !ready
	) else note_failure("aligned request was not accepted");

	a_misaligned_rejected : assert property (
		@(posedge clk) disable iff (reset)
		misalign_armed |-> (bad_addr && ready)
	) else note_failure("misaligned word request was not rejected with ready held high");

	task automatic start_test(input string name);
		test_name = name;
		errors_at_start = error_count;
	endtask

	task automatic finish_test();
		if (error_count == errors_at_start) begin
			pass_count++;
			$display("test %s: ok", test_name);
		end else begin
			fail_count++;
			$display("test %s: %0d errors", test_name, error_count - errors_at_start);
		end
	endtask

	task automatic run_access(input xm_op_e acc_op, input xm_size_e acc_size,
			input logic [word_bits-1:0] acc_addr, input logic [word_bits-1:0] acc_data);
		logic mapped;
		int idx;
		int waited;
		idx = int'(acc_addr);
		mapped = (idx / 2) < mem_words;
		check_data = mapped && (acc_op == op_read);
		exp_rd_err = !mapped && (acc_op == op_read);
		exp_wr_err = !mapped && (acc_op == op_write);
		if (check_data && acc_size == size_word)
			exp_data = {ref_mem[idx+1], ref_mem[idx]};
		else if (check_data)
			exp_data = {8'h00, ref_mem[idx]}; // Zero-extended byte
		en = 1'b1;
		op = acc_op;
		size = acc_size;
		addr = acc_addr;
		wr_data = acc_data;
		@(posedge clk); // Accepted here
		#1;
		en = 1'b0;
		if (mapped && acc_op == op_write) begin
			ref_mem[idx] = acc_data[7:0];
			if (acc_size == size_word)
				ref_mem[idx+1] = acc_data[15:8];
		end
		waited = 0;
		while (!ready && waited < timeout_cycles + 4) begin
			@(posedge clk);
			#1;
			waited++;
		end
		if (!ready)
			note_failure("ready did not return after the access");
		@(posedge clk); // Lets the assertions see ready rise
		#1;
	endtask

	task automatic probe_misaligned(input logic [word_bits-1:0] acc_addr,
			input logic [word_bits-1:0] acc_data);
		en = 1'b1;
		op = op_write;
		size = size_word;
		addr = acc_addr;
		wr_data = acc_data;
		misalign_armed = 1'b1;
		repeat (3) @(posedge clk);
		#1;
		en = 1'b0;
		misalign_armed = 1'b0;
	endtask

	initial begin
		logic [31:0] rnd;
		xm_size_e r_size;
		logic [word_bits-1:0] r_addr;
		en = 1'b0;
		op = op_read;
		size = size_word;
		addr = '0;
		wr_data = '0;
		check_data = 1'b0;
		exp_data = '0;
		exp_rd_err = 1'b0;
		exp_wr_err = 1'b0;
		misalign_armed = 1'b0;
		error_count = 0;
		pass_count = 0;
		fail_count = 0;
		seed = 92;
		@(negedge reset);

		start_test("word_round_trip");
		run_access(op_write, size_word, 16'h0040, 16'ha55a);
		run_access(op_read, size_word, 16'h0040, 16'h0000);
		finish_test();

		start_test("byte_lanes"); // Upper bytes of wr_data must be dropped
		run_access(op_write, size_byte, 16'h0052, 16'hee11);
		run_access(op_write, size_byte, 16'h0053, 16'hdd22);
		run_access(op_read, size_word, 16'h0052, 16'h0000);
		finish_test();

		start_test("byte_read_odd");
		run_access(op_write, size_word, 16'h0060, 16'hbeef);
		run_access(op_read, size_byte, 16'h0061, 16'h0000);
		finish_test();

		start_test("misaligned_word");
		run_access(op_write, size_word, 16'h0070, 16'h1234);
		probe_misaligned(16'h0071, 16'hffff);
		run_access(op_read, size_word, 16'h0070, 16'h0000);
		finish_test();

		start_test("unmapped_address"); // Word 512 lies past the decoded range
		run_access(op_read, size_word, 16'h0400, 16'h0000);
		run_access(op_write, size_word, 16'h0402, 16'h7777);
		run_access(op_read, size_word, 16'h0040, 16'h0000);
		finish_test();

		start_test("random_traffic");
		for (int w = 0; w < 16; w++)
			run_access(op_write, size_word, word_bits'(2 * w), word_bits'(2 * w) ^ 16'hc35a);
		for (int i = 0; i < 40; i++) begin
			rnd = $random(seed);
			r_size = rnd[1] ? size_byte : size_word;
			r_addr = {11'd0, rnd[6:3], (r_size == size_byte) && rnd[2]};
			run_access(rnd[0] ? op_write : op_read, r_size, r_addr, rnd[31:16]);
		end
		finish_test();

		$display("tests passed %0d, failed %0d", pass_count, fail_count);
		if (fail_count == 0 && error_count == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

	initial begin
		repeat (watchdog_cycles) @(posedge clk);
		$display("watchdog expired before the tests finished");
		$display("TESTBENCH FAILED");
		$finish;
	end

endmodule : xm_bus_tb

/* all.f */
source/xm_bus_pkg.sv
source/byte_lane_unit.sv
source/access_timer.sv
source/ext_memory.sv
source/bus_interfacer.sv
source/xm_bus_top.sv
testbench/tb_clock_gen.sv
testbench/xm_bus_tb.sv

/* run_sim.sh */
#!/bin/sh
# Verilator build and run of the bus testbench
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module xm_bus_tb -f all.f -o xm_bus_sim \
	&& ./obj_dir/xm_bus_sim > sim.log 2>&1 \
	|| echo "build or simulation did not complete" >> sim.log
grep -q "TESTBENCH PASSED" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }
